/* flist.f */
src/mips_pkg.sv
src/mips_decoder.sv
src/mips_regfile.sv
src/mips_hazard.sv
src/mips_execute.sv
src/mips.sv
tests/tb_mips.sv

/* Makefile */
SRCS := $(shell cat flist.f)

obj_dir/Vtb_mips: flist.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_mips -f flist.f

.PHONY: run clean

run: obj_dir/Vtb_mips
	./obj_dir/Vtb_mips | grep -F '*** PASSED ***'

clean:
	rm -rf obj_dir

/* tests/tb_mips.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mips;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } store_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        mem_write;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;

  logic [31:0] imem [64];
  logic [31:0] dmem [64];

  // program table with one row per program
  logic [31:0] prog_instr [5][16];
  logic [31:0] prog_data  [5][4];
  store_t      st_exp     [5][4];
  int          st_cnt     [5];

  int errors;
  int checked;
  int seen;
  int cur;
  int cycles;

  mips i_mips (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc        (pc),
    .instr     (instr),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  always #50 clk = ~clk;

  // memories answer in the same cycle
  assign instr     = imem[pc[7:2]];
  assign mem_rdata = dmem[mem_addr[7:2]];

  function automatic logic [31:0] rtype(input logic [5:0] funct, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt);
    rtype = {6'h00, rs, rt, rd, 5'h00, funct};
  endfunction

  function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rt,
                                        input logic [4:0] rs, input logic [15:0] imm);
    itype = {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jtype(input int idx);
    jtype = {6'h02, 26'(idx)};
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checked++;
    if (got !== exp)
    begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // ------------------------------------------------------------------------
  // store checker
  // ------------------------------------------------------------------------
  always @(negedge clk)
    if (rst_n === 1'b1 && mem_write === 1'b1)
    begin
      if (seen < st_cnt[cur])
      begin
        compare("mem_addr", mem_addr, st_exp[cur][seen].addr);
        compare("mem_wdata", mem_wdata, st_exp[cur][seen].data);
      end
      else
      begin
        $display("program %0d made an unexpected store to address %h", cur, mem_addr);
        errors++;
      end
      seen++;
      dmem[mem_addr[7:2]] = mem_wdata;
    end

  task automatic fill_table;
    for (int p = 0; p < 5; p++)
      for (int i = 0; i < 16; i++)
        prog_instr[p][i] = 32'h0; // sll r0 style no-op
    // immediates and ALU
    prog_instr[0][0]  = itype(6'h08, 1, 0, 16'hfffb);   // addi r1 = -5
    prog_instr[0][1]  = itype(6'h0d, 2, 0, 16'h8001);   // ori zero extended
    prog_instr[0][2]  = itype(6'h0f, 3, 0, 16'h1234);   // lui
    prog_instr[0][3]  = itype(6'h09, 4, 3, 16'h5678);   // addiu
    prog_instr[0][4]  = itype(6'h0a, 5, 1, 16'h0001);   // signed slti
    prog_instr[0][5]  = rtype(6'h2a, 6, 1, 5);          // slt
    prog_instr[0][6]  = itype(6'h2b, 4, 0, 16'h0040);
    prog_instr[0][7]  = rtype(6'h20, 7, 1, 2);          // add
    prog_instr[0][8]  = rtype(6'h21, 8, 5, 6);          // addu
    prog_instr[0][9]  = rtype(6'h22, 9, 4, 2);          // sub
    prog_instr[0][10] = rtype(6'h24, 10, 9, 1);         // and
    prog_instr[0][11] = rtype(6'h23, 11, 10, 8);        // subu
    prog_instr[0][12] = rtype(6'h25, 12, 11, 7);        // or
    prog_instr[0][13] = itype(6'h2b, 12, 0, 16'h0044);
    prog_instr[0][14] = itype(6'h2b, 8, 0, 16'h0048);
    prog_instr[0][15] = jtype(15);
    // forwarding and r0
    prog_instr[1][0]  = itype(6'h08, 1, 0, 16'h0005);
    prog_instr[1][1]  = rtype(6'h20, 2, 1, 1);
    prog_instr[1][2]  = rtype(6'h20, 3, 2, 1);
    prog_instr[1][3]  = rtype(6'h20, 4, 3, 2);
    prog_instr[1][4]  = itype(6'h2b, 4, 0, 16'h0040);
    prog_instr[1][5]  = itype(6'h08, 0, 0, 16'h0007);   // write to r0
    prog_instr[1][6]  = itype(6'h2b, 0, 0, 16'h0048);
    prog_instr[1][7]  = rtype(6'h20, 5, 0, 1);
    prog_instr[1][8]  = itype(6'h2b, 5, 0, 16'h0044);
    prog_instr[1][9]  = jtype(9);
    // load-use
    prog_instr[2][0]  = itype(6'h08, 2, 0, 16'h0100);
    prog_instr[2][1]  = itype(6'h23, 1, 0, 16'h0004);   // lw
    prog_instr[2][2]  = rtype(6'h20, 3, 1, 2);
    prog_instr[2][3]  = itype(6'h2b, 3, 0, 16'h0040);
    prog_instr[2][4]  = itype(6'h23, 4, 0, 16'h0000);
    prog_instr[2][5]  = itype(6'h2b, 4, 0, 16'h0044);   // lw straight into sw
    prog_instr[2][6]  = jtype(6);
    // branches
    prog_instr[3][0]  = itype(6'h08, 1, 0, 16'h0003);
    prog_instr[3][1]  = itype(6'h08, 2, 0, 16'h0003);
    prog_instr[3][2]  = itype(6'h04, 2, 1, 16'h0002);   // beq taken
    prog_instr[3][3]  = itype(6'h2b, 1, 0, 16'h0040);
    prog_instr[3][4]  = itype(6'h2b, 1, 0, 16'h0044);
    prog_instr[3][5]  = itype(6'h05, 2, 1, 16'h0001);   // bne not taken
    prog_instr[3][6]  = itype(6'h2b, 1, 0, 16'h0048);
    prog_instr[3][7]  = itype(6'h08, 3, 0, 16'h0004);
    prog_instr[3][8]  = itype(6'h05, 3, 1, 16'h0001);   // bne taken
    prog_instr[3][9]  = itype(6'h2b, 3, 0, 16'h004c);
    prog_instr[3][10] = itype(6'h04, 3, 1, 16'h0001);   // beq not taken
    prog_instr[3][11] = itype(6'h2b, 3, 0, 16'h0050);
    prog_instr[3][12] = jtype(12);
    // jump
    prog_instr[4][0]  = itype(6'h08, 1, 0, 16'h0077);
    prog_instr[4][1]  = jtype(4);
    prog_instr[4][2]  = itype(6'h2b, 0, 0, 16'h0040);
    prog_instr[4][3]  = itype(6'h2b, 0, 0, 16'h0044);
    prog_instr[4][4]  = itype(6'h2b, 1, 0, 16'h0048);   // marker
    prog_instr[4][5]  = jtype(5);

    for (int p = 0; p < 5; p++)
      for (int i = 0; i < 4; i++)
        prog_data[p][i] = 32'h0;
    prog_data[2][0] = 32'ha5a5_0000;
    prog_data[2][1] = 32'h0000_1234;

    st_cnt = '{3, 3, 2, 2, 1};
    st_exp[0][0] = '{32'h40, 32'h1234_5678};
    st_exp[0][1] = '{32'h44, 32'h1233_fffd};
    st_exp[0][2] = '{32'h48, 32'h0000_0002};
    st_exp[1][0] = '{32'h40, 32'h0000_0019};
    st_exp[1][1] = '{32'h48, 32'h0000_0000};
    st_exp[1][2] = '{32'h44, 32'h0000_0005};
    st_exp[2][0] = '{32'h40, 32'h0000_1334};
    st_exp[2][1] = '{32'h44, 32'ha5a5_0000};
    st_exp[3][0] = '{32'h48, 32'h0000_0003};
    st_exp[3][1] = '{32'h50, 32'h0000_0004};
    st_exp[4][0] = '{32'h48, 32'h0000_0077};
  endtask

  task automatic load_program(input int p);
    for (int i = 0; i < 64; i++)
    begin
      imem[i] = (i < 16) ? prog_instr[p][i] : 32'h0;
      dmem[i] = (i < 4) ? prog_data[p][i] : (32'hd00d_0000 | 32'(i * 4));
    end
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial
  begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    errors  = 0;
    checked = 0;
    seen    = 0;
    cur     = 0;
    fill_table();
    load_program(0);
    for (int p = 0; p < 5; p++)
    begin
      @(posedge clk);
      rst_n <= 1'b0;
      @(posedge clk);
      cur  = p;
      seen = 0;
      load_program(p);
      repeat (15) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      compare("pc", pc, 32'h0); // first fetch after reset
      cycles = 0;
      while (seen < st_cnt[p] && cycles < 200)
      begin
        @(posedge clk);
        cycles++;
      end
      if (seen < st_cnt[p])
      begin
        $display("program %0d hung, only %0d of %0d stores seen", p, seen, st_cnt[p]);
        errors++;
      end
      repeat (20) @(posedge clk); // catch any store past the list
    end
    $display("errors: %0d, checks: %0d", errors, checked);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* src/mips.sv */
`timescale 1ns/10ps
`default_nettype none

module mips (
  input  logic                        clk,
  input  logic                        rst_n,
  output logic [mips_pkg::data_w-1:0] pc,
  input  logic [mips_pkg::data_w-1:0] instr,
  output logic                        mem_write,
  output logic [mips_pkg::data_w-1:0] mem_addr,
  output logic [mips_pkg::data_w-1:0] mem_wdata,
  input  logic [mips_pkg::data_w-1:0] mem_rdata
);

  logic [mips_pkg::data_w-1:0]     pc_plus4;
  logic [mips_pkg::data_w-1:0]     pc_next;
  logic [mips_pkg::data_w-1:0]     jump_target;
  logic [mips_pkg::data_w-1:0]     fd_instr;
  logic [mips_pkg::data_w-1:0]     fd_pc4;
  logic                            fd_valid;
  mips_pkg::ctrl_t                 dec_ctrl_raw;
  mips_pkg::ctrl_t                 dec_ctrl;
  logic                            bubble;
  logic [mips_pkg::data_w-1:0]     imm_ext;
  logic [mips_pkg::data_w-1:0]     rd1;
  logic [mips_pkg::data_w-1:0]     rd2;
  mips_pkg::id_ex_t                id_ex;
  mips_pkg::id_ex_t                id_ex_d;
  mips_pkg::ex_mem_t               ex_mem;
  mips_pkg::ex_mem_t               ex_mem_d;
  mips_pkg::mem_wb_t               mem_wb;
  mips_pkg::mem_wb_t               mem_wb_d;
  logic [1:0]                      fwd_a;
  logic [1:0]                      fwd_b;
  logic                            stall;
  logic                            flush_decode;
  logic                            branch_taken;
  logic [mips_pkg::data_w-1:0]     branch_target;
  logic [mips_pkg::data_w-1:0]     ex_alu_result;
  logic [mips_pkg::data_w-1:0]     ex_store_data;
  logic [mips_pkg::reg_addr_w-1:0] ex_dest;
  logic [mips_pkg::data_w-1:0]     wb_result;

  // --------------------------------------------------------------------------
  // fetch
  // --------------------------------------------------------------------------
  assign pc_plus4    = pc + 32'd4;
  assign jump_target = {fd_pc4[31:28], fd_instr[25:0], 2'b00};

  always_comb
  begin
    if (branch_taken)
      pc_next = branch_target;
    else if (dec_ctrl.jump)
      pc_next = jump_target;
    else
      pc_next = pc_plus4;
  end

  always_ff @(posedge clk)
    if (!rst_n)
      pc <= '0;
    else if (!stall)
      pc <= pc_next;

  always_ff @(posedge clk)
    if (!rst_n)
      fd_valid <= 1'b0;
    else if (flush_decode || dec_ctrl.jump)
      fd_valid <= 1'b0; // squash the fetched word
    else if (!stall)
      fd_valid <= 1'b1;

  always_ff @(posedge clk)
    if (!stall)
    begin
      fd_instr <= instr;
      fd_pc4   <= pc_plus4;
    end

  // --------------------------------------------------------------------------
  // decode
  // --------------------------------------------------------------------------
  mips_decoder i_decoder (
    .op   (mips_pkg::op_e'(fd_instr[31:26])),
    .ctrl (dec_ctrl_raw)
  );

  assign bubble   = stall || flush_decode || !fd_valid;
  assign dec_ctrl = bubble ? '0 : dec_ctrl_raw;

  always_comb
  begin
    if (dec_ctrl_raw.shift16)
      imm_ext = {fd_instr[15:0], 16'b0}; // lui
    else if (dec_ctrl_raw.sign_ext)
      imm_ext = {{16{fd_instr[15]}}, fd_instr[15:0]};
    else
      imm_ext = {16'b0, fd_instr[15:0]};
  end

  mips_regfile i_regfile (
    .clk (clk),
    .we  (mem_wb.reg_write),
    .ra1 (fd_instr[25:21]),
    .ra2 (fd_instr[20:16]),
    .wa  (mem_wb.dest),
    .wd  (wb_result),
    .rd1 (rd1),
    .rd2 (rd2)
  );

  mips_hazard i_hazard (
    .dec_rs       (fd_instr[25:21]),
    .dec_rt       (fd_instr[20:16]),
    .id_ex        (id_ex),
    .ex_mem       (ex_mem),
    .mem_wb       (mem_wb),
    .branch_taken (branch_taken),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b),
    .stall        (stall),
    .flush_decode (flush_decode)
  );

  always_comb
  begin
    id_ex_d.reg_write  = dec_ctrl.reg_write;
    id_ex_d.mem_to_reg = dec_ctrl.mem_to_reg;
    id_ex_d.mem_write  = dec_ctrl.mem_write;
    id_ex_d.alu_src    = dec_ctrl.alu_src;
    id_ex_d.reg_dst    = dec_ctrl.reg_dst;
    id_ex_d.branch_eq  = dec_ctrl.branch_eq;
    id_ex_d.branch_ne  = dec_ctrl.branch_ne;
    id_ex_d.alu_mode   = dec_ctrl.alu_mode;
    id_ex_d.pc_plus4   = fd_pc4;
    id_ex_d.rs_val     = rd1;
    id_ex_d.rt_val     = rd2;
    id_ex_d.imm        = imm_ext;
    id_ex_d.rs         = fd_instr[25:21];
    id_ex_d.rt         = fd_instr[20:16];
    id_ex_d.rd         = fd_instr[15:11];
    id_ex_d.funct      = mips_pkg::funct_e'(fd_instr[5:0]);
    id_ex_d.valid      = !bubble;
  end

  // --------------------------------------------------------------------------
  // execute, memory, writeback
  // --------------------------------------------------------------------------
  mips_execute i_execute (
    .id_ex         (id_ex),
    .mem_result    (ex_mem.alu_result),
    .wb_result     (wb_result),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b),
    .alu_result    (ex_alu_result),
    .store_data    (ex_store_data),
    .dest          (ex_dest),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  assign ex_mem_d = '{reg_write:  id_ex.reg_write,
                      mem_to_reg: id_ex.mem_to_reg,
                      mem_write:  id_ex.mem_write,
                      alu_result: ex_alu_result,
                      store_data: ex_store_data,
                      dest:       ex_dest};

  assign mem_wb_d = '{reg_write:  ex_mem.reg_write,
                      mem_to_reg: ex_mem.mem_to_reg,
                      alu_result: ex_mem.alu_result,
                      load_data:  mem_rdata,
                      dest:       ex_mem.dest};

  always_ff @(posedge clk)
    if (!rst_n)
    begin
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end
    else
    begin
      id_ex  <= id_ex_d;
      ex_mem <= ex_mem_d;
      mem_wb <= mem_wb_d;
    end

  assign mem_write = ex_mem.mem_write;
  assign mem_addr  = ex_mem.alu_result;
  assign mem_wdata = ex_mem.store_data;

  assign wb_result = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

`default_nettype wire

/* src/mips_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_execute (
  input  mips_pkg::id_ex_t                id_ex,
  input  logic [mips_pkg::data_w-1:0]     mem_result,
  input  logic [mips_pkg::data_w-1:0]     wb_result,
  input  logic [1:0]                      fwd_a,
  input  logic [1:0]                      fwd_b,
  output logic [mips_pkg::data_w-1:0]     alu_result,
  output logic [mips_pkg::data_w-1:0]     store_data,
  output logic [mips_pkg::reg_addr_w-1:0] dest,
  output logic                            branch_taken,
  output logic [mips_pkg::data_w-1:0]     branch_target
);

  mips_pkg::alu_op_e           alu_op;
  logic [mips_pkg::data_w-1:0] src_a;
  logic [mips_pkg::data_w-1:0] src_b_reg;
  logic [mips_pkg::data_w-1:0] src_b;
  logic                        equal;

  function automatic logic [mips_pkg::data_w-1:0] fwd_mux(
    input logic [1:0]                  sel,
    input logic [mips_pkg::data_w-1:0] reg_val,
    input logic [mips_pkg::data_w-1:0] mem_val,
    input logic [mips_pkg::data_w-1:0] wb_val
  );
    case (sel)
      mips_pkg::fwd_mem: fwd_mux = mem_val;
      mips_pkg::fwd_wb:  fwd_mux = wb_val;
      default:           fwd_mux = reg_val;
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // ALU decode
  // ------------------------------------------------------------------------
  always_comb
  begin
    case (id_ex.alu_mode)
      mips_pkg::mode_add: alu_op = mips_pkg::alu_add;
      mips_pkg::mode_sub: alu_op = mips_pkg::alu_sub;
      mips_pkg::mode_or:  alu_op = mips_pkg::alu_or;
      mips_pkg::mode_slt: alu_op = mips_pkg::alu_slt;
      default:
        case (id_ex.funct)
          mips_pkg::fn_add, mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
          mips_pkg::fn_sub, mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and:                    alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or:                     alu_op = mips_pkg::alu_or;
          mips_pkg::fn_slt:                    alu_op = mips_pkg::alu_slt;
          default:                             alu_op = mips_pkg::alu_add;
        endcase
    endcase
  end

  // ------------------------------------------------------------------------
  // operands and ALU
  // ------------------------------------------------------------------------
  assign src_a     = fwd_mux(fwd_a, id_ex.rs_val, mem_result, wb_result);
  assign src_b_reg = fwd_mux(fwd_b, id_ex.rt_val, mem_result, wb_result);
  assign src_b     = id_ex.alu_src ? id_ex.imm : src_b_reg;
  assign store_data = src_b_reg; // forwarded sw data

  always_comb
  begin
    case (alu_op)
      mips_pkg::alu_add: alu_result = src_a + src_b;
      mips_pkg::alu_sub: alu_result = src_a - src_b;
      mips_pkg::alu_and: alu_result = src_a & src_b;
      mips_pkg::alu_or:  alu_result = src_a | src_b;
      mips_pkg::alu_slt:
        alu_result = {{(mips_pkg::data_w-1){1'b0}}, $signed(src_a) < $signed(src_b)};
      default:           alu_result = '0;
    endcase
  end

  // branch compare uses the forwarded register values and never the immediate
  assign equal        = (src_a == src_b_reg);
  assign branch_taken = id_ex.valid &&
                        ((id_ex.branch_eq && equal) || (id_ex.branch_ne && !equal));
  assign branch_target = id_ex.pc_plus4 + {id_ex.imm[mips_pkg::data_w-3:0], 2'b00};

  assign dest = id_ex.reg_dst ? id_ex.rd : id_ex.rt;

endmodule

`default_nettype wire

/* src/mips_hazard.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_hazard (
  input  logic [mips_pkg::reg_addr_w-1:0] dec_rs,
  input  logic [mips_pkg::reg_addr_w-1:0] dec_rt,
  input  mips_pkg::id_ex_t                id_ex,
  input  mips_pkg::ex_mem_t               ex_mem,
  input  mips_pkg::mem_wb_t               mem_wb,
  input  logic                            branch_taken,
  output logic [1:0]                      fwd_a,
  output logic [1:0]                      fwd_b,
  output logic                            stall,
  output logic                            flush_decode
);

  logic load_in_ex;

  // the younger memory stage wins over writeback
  function automatic logic [1:0] fwd_sel(
    input logic [mips_pkg::reg_addr_w-1:0] src,
    input mips_pkg::ex_mem_t               em,
    input mips_pkg::mem_wb_t               mw
  );
    if (src != '0 && em.reg_write && em.dest == src)
      fwd_sel = mips_pkg::fwd_mem;
    else if (src != '0 && mw.reg_write && mw.dest == src)
      fwd_sel = mips_pkg::fwd_wb;
    else
      fwd_sel = mips_pkg::fwd_none;
  endfunction

  assign fwd_a = fwd_sel(id_ex.rs, ex_mem, mem_wb);
  assign fwd_b = fwd_sel(id_ex.rt, ex_mem, mem_wb);

  // ------------------------------------------------------------------------
  // load-use and squash
  // ------------------------------------------------------------------------
  assign load_in_ex = id_ex.mem_to_reg && id_ex.reg_write && id_ex.rt != '0; // lw dest is rt
  assign stall      = load_in_ex && (id_ex.rt == dec_rs || id_ex.rt == dec_rt);

  assign flush_decode = branch_taken;

endmodule

`default_nettype wire

/* src/mips_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_regfile (
  input  logic                            clk,
  input  logic                            we,
  input  logic [mips_pkg::reg_addr_w-1:0] ra1,
  input  logic [mips_pkg::reg_addr_w-1:0] ra2,
  input  logic [mips_pkg::reg_addr_w-1:0] wa,
  input  logic [mips_pkg::data_w-1:0]     wd,
  output logic [mips_pkg::data_w-1:0]     rd1,
  output logic [mips_pkg::data_w-1:0]     rd2
);

  logic [mips_pkg::data_w-1:0] regs [32];

  // r0 reads zero and a same-cycle write passes straight through
  function automatic logic [mips_pkg::data_w-1:0] read_port(
    input logic [mips_pkg::reg_addr_w-1:0] ra
  );
    if (ra == '0)
      read_port = '0;
    else if (we && wa == ra)
      read_port = wd;
    else
      read_port = regs[ra];
  endfunction

  always_ff @(posedge clk)
    if (we && wa != '0)
      regs[wa] <= wd;

  assign rd1 = read_port(ra1);
  assign rd2 = read_port(ra2);

endmodule

`default_nettype wire

/* src/mips_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_decoder (
  input  mips_pkg::op_e   op,
  output mips_pkg::ctrl_t ctrl
);

  always_comb
  begin
    ctrl = '0; // unknown opcode is a no-op
    case (op)
      mips_pkg::op_rtype:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = 1'b1;
        ctrl.alu_mode  = mips_pkg::mode_funct;
      end
      mips_pkg::op_lw:
      begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.sign_ext   = 1'b1;
      end
      mips_pkg::op_sw:
      begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.sign_ext  = 1'b1;
      end
      mips_pkg::op_beq:
      begin
        ctrl.branch_eq = 1'b1;
        ctrl.sign_ext  = 1'b1;
        ctrl.alu_mode  = mips_pkg::mode_sub;
      end
      mips_pkg::op_bne:
      begin
        ctrl.branch_ne = 1'b1;
        ctrl.sign_ext  = 1'b1;
        ctrl.alu_mode  = mips_pkg::mode_sub;
      end
      mips_pkg::op_addi, mips_pkg::op_addiu:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.sign_ext  = 1'b1;
      end
      mips_pkg::op_slti:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.sign_ext  = 1'b1;
        ctrl.alu_mode  = mips_pkg::mode_slt;
      end
      mips_pkg::op_ori:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1; // zero extended
        ctrl.alu_mode  = mips_pkg::mode_or;
      end
      mips_pkg::op_lui:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.shift16   = 1'b1; // add on r0 gives imm << 16
      end
      mips_pkg::op_j:      ctrl.jump = 1'b1;
      default:             ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

/* src/mips_pkg.sv */
`default_nettype none

package mips_pkg;

  localparam int data_w     = 32;
  localparam int reg_addr_w = 5;

  // forwarding selects
  localparam logic [1:0] fwd_none = 2'b00;
  localparam logic [1:0] fwd_mem  = 2'b01;
  localparam logic [1:0] fwd_wb   = 2'b10;

  // --------------------------------------------------------------------------
  // instruction fields and ALU encodings
  // --------------------------------------------------------------------------
  typedef enum logic [5:0] {
    op_rtype = 6'b000000,
    op_j     = 6'b000010,
    op_beq   = 6'b000100,
    op_bne   = 6'b000101,
    op_addi  = 6'b001000,
    op_addiu = 6'b001001,
    op_slti  = 6'b001010,
    op_ori   = 6'b001101,
    op_lui   = 6'b001111,
    op_lw    = 6'b100011,
    op_sw    = 6'b101011
  } op_e;

  typedef enum logic [5:0] {
    fn_add  = 6'b100000,
    fn_addu = 6'b100001,
    fn_sub  = 6'b100010,
    fn_subu = 6'b100011,
    fn_and  = 6'b100100,
    fn_or   = 6'b100101,
    fn_slt  = 6'b101010
  } funct_e;

  typedef enum logic [2:0] {
    alu_and = 3'b000,
    alu_or  = 3'b001,
    alu_add = 3'b010,
    alu_sub = 3'b110,
    alu_slt = 3'b111
  } alu_op_e;

  // five classes need three bits
  typedef enum logic [2:0] {
    mode_add   = 3'd0,
    mode_sub   = 3'd1,
    mode_or    = 3'd2,
    mode_slt   = 3'd3,
    mode_funct = 3'd4
  } alu_mode_e;

  // --------------------------------------------------------------------------
  // control word and pipeline registers
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic      reg_write;
    logic      mem_to_reg;
    logic      mem_write;
    logic      alu_src;
    logic      reg_dst;
    logic      branch_eq;
    logic      branch_ne;
    logic      jump;
    logic      sign_ext;
    logic      shift16;
    alu_mode_e alu_mode;
  } ctrl_t;

  typedef struct packed {
    logic                  reg_write;
    logic                  mem_to_reg;
    logic                  mem_write;
    logic                  alu_src;
    logic                  reg_dst;
    logic                  branch_eq;
    logic                  branch_ne;
    alu_mode_e             alu_mode;
    logic [data_w-1:0]     pc_plus4;
    logic [data_w-1:0]     rs_val;
    logic [data_w-1:0]     rt_val;
    logic [data_w-1:0]     imm;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    funct_e                funct;
    logic                  valid;
  } id_ex_t;

  typedef struct packed {
    logic                  reg_write;
    logic                  mem_to_reg;
    logic                  mem_write;
    logic [data_w-1:0]     alu_result;
    logic [data_w-1:0]     store_data;
    logic [reg_addr_w-1:0] dest;
  } ex_mem_t;

  typedef struct packed {
    logic                  reg_write;
    logic                  mem_to_reg;
    logic [data_w-1:0]     alu_result;
    logic [data_w-1:0]     load_data;
    logic [reg_addr_w-1:0] dest;
  } mem_wb_t;

endpackage

`default_nettype wire
